// File: verilog/isa_pkg.sv
package isa_pkg;

	//////////////////////////////////////////////////
	// Major opcodes, bits 31:26 of every instruction
	//////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OPC_J     = 6'h00,
		OPC_JAL   = 6'h01,
		OPC_BNF   = 6'h03,
		OPC_BF    = 6'h04,
		OPC_NOP   = 6'h05,
		OPC_MOVHI = 6'h06,
		OPC_SYS   = 6'h08,
		OPC_RFE   = 6'h09,
		OPC_JR    = 6'h11,
		OPC_JALR  = 6'h12,
		OPC_LWZ   = 6'h21,
		OPC_SW    = 6'h35,
		OPC_ALU   = 6'h38
	} opcode_e;

	// No-op inserted for flush, squash and fetch errors
	localparam logic [31:0] NOP_BUBBLE = {OPC_NOP, 26'h041_0000};

	// No-op shown while a fetch is still outstanding
	localparam logic [31:0] NOP_STALL = {OPC_NOP, 26'h061_0000};

	//////////////////////////////////////////////////
	// Cache response tags
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ITAG_NI = 4'h0,  // normal fetch
		ITAG_BE = 4'hB,  // bus error
		ITAG_PE = 4'hC,  // page fault
		ITAG_TE = 4'hD   // TLB miss
	} itag_e;

endpackage

// File: verilog/fetch_pkg.sv
package fetch_pkg;

	//////////////////////////////////////////////////
	// Instruction cache port
	//////////////////////////////////////////////////

	// Level request, adr stable until ack or err
	typedef struct packed {
		logic        cycstb;
		logic [31:0] adr;
	} ic_req_t;

	// Response, adr echoes the request it answers
	typedef struct packed {
		logic [31:0]   dat;
		logic          ack;
		logic          err;
		logic [31:0]   adr;
		isa_pkg::itag_e tag;
	} ic_rsp_t;

	// Toward decode
	typedef struct packed {
		logic [31:0] insn;
		logic [31:0] pc;
		logic        itlbmiss;
		logic        immufault;
		logic        ibuserr;
	} if_out_t;

	//////////////////////////////////////////////////
	// Exceptions and vectors
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		EXC_BUS  = 2'd0,
		EXC_IMMU = 2'd1,
		EXC_ITLB = 2'd2,
		EXC_SYS  = 2'd3
	} exc_e;

	localparam logic [31:0] RESET_OFFSET    = 32'h0000_0100;
	localparam logic [31:0] VEC_OFFSET_BUS  = 32'h0000_0200;
	localparam logic [31:0] VEC_OFFSET_IMMU = 32'h0000_0400;
	localparam logic [31:0] VEC_OFFSET_ITLB = 32'h0000_0A00;
	localparam logic [31:0] VEC_OFFSET_SYS  = 32'h0000_0C00;

	// Offset of a cause from the vector base
	function automatic logic [31:0] vec_offset(exc_e cause);
		case (cause)
			EXC_BUS:  return VEC_OFFSET_BUS;
			EXC_IMMU: return VEC_OFFSET_IMMU;
			EXC_ITLB: return VEC_OFFSET_ITLB;
			default:  return VEC_OFFSET_SYS;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Configuration registers
	//////////////////////////////////////////////////

	// Vector base is 8 KiB aligned
	localparam int EVBAR_LSB = 13;

	typedef enum logic {
		CFG_EVBAR = 1'b0,
		CFG_CTRL  = 1'b1
	} cfg_addr_e;

	typedef struct packed {
		logic [31:0] evbar;
		logic        fetch_en;
	} fetch_cfg_t;

endpackage

// File: verilog/fetch_cfg_regs.sv
`timescale 1ns/100ps

module fetch_cfg_regs (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  cfg_we_i,
	input  fetch_pkg::cfg_addr_e  cfg_addr_i,
	input  logic [31:0]           cfg_wdata_i,
	output logic [31:0]           cfg_rdata_o,
	output fetch_pkg::fetch_cfg_t cfg_o
);

	import fetch_pkg::*;

	// Only the upper bits of the base are stored
	logic [31:EVBAR_LSB] evbar_q;
	logic                fetch_en_q;

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			evbar_q    <= '0;
			// Fetch starts right out of reset
			fetch_en_q <= 1'b1;
		end else if (cfg_we_i) begin
			if (cfg_addr_i == CFG_EVBAR) begin
				// Low bits dropped on write
				evbar_q <= cfg_wdata_i[31:EVBAR_LSB];
			end else begin
				fetch_en_q <= cfg_wdata_i[0];
			end
		end
	end

	//////////////////////////////////////////////////
	// Read-back and outputs
	//////////////////////////////////////////////////

	always_comb begin
		case (cfg_addr_i)
			CFG_EVBAR: cfg_rdata_o = {evbar_q, {EVBAR_LSB{1'b0}}};
			// Enable sits in bit 0
			default:   cfg_rdata_o = {31'd0, fetch_en_q};
		endcase
	end

	// Base reads as zero below bit 13
	assign cfg_o.evbar    = {evbar_q, {EVBAR_LSB{1'b0}}};
	assign cfg_o.fetch_en = fetch_en_q;

endmodule

// File: verilog/fetch_pc_gen.sv
`timescale 1ns/100ps

module fetch_pc_gen (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  fetch_pkg::fetch_cfg_t cfg_i,
	input  fetch_pkg::ic_rsp_t    ic_rsp_i,
	input  logic                  freeze_i,
	input  logic                  saving_i,
	input  logic                  redirect_i,
	input  logic [31:0]           redirect_pc_i,
	input  logic                  except_i,
	input  fetch_pkg::exc_e       except_cause_i,
	output fetch_pkg::ic_req_t    ic_req_o,
	output logic                  flushpipe_o
);

	import fetch_pkg::*;

	// Word address of the current fetch
	logic [31:2] pc_q;
	logic [31:2] pc_d;
	// Bit 0 marker, first fetch after a flush
	logic        mark_q;
	logic        mark_d;
	logic        cycstb_q;
	logic        cycstb_d;
	// Saved instruction waiting in the stage
	logic        hold_q;
	logic        hold_d;
	logic        done;
	logic [31:0] exc_target;

	// Fetch completes on ack or err
	assign done = cycstb_q & (ic_rsp_i.ack | ic_rsp_i.err);

	// Flush is combinational from the control pulses
	assign flushpipe_o = except_i | redirect_i;

	assign exc_target = cfg_i.evbar + vec_offset(except_cause_i);

	//////////////////////////////////////////////////
	// Next address and request level
	//////////////////////////////////////////////////

	always_comb begin
		pc_d     = pc_q;
		mark_d   = mark_q;
		cycstb_d = cycstb_q;
		hold_d   = hold_q;

		if (except_i) begin
			// Exception wins over redirect
			pc_d     = exc_target[31:2];
			mark_d   = 1'b1;
			hold_d   = 1'b0;
			cycstb_d = cfg_i.fetch_en;
		end else if (redirect_i) begin
			pc_d     = redirect_pc_i[31:2];
			mark_d   = 1'b1;
			hold_d   = 1'b0;
			cycstb_d = cfg_i.fetch_en;
		end else begin
			// Sequential step
			if (done) begin
				pc_d   = pc_q + 30'd1;
				mark_d = 1'b0;
			end

			if (saving_i) begin
				// Stage took it under freeze, pause
				hold_d   = 1'b1;
				cycstb_d = 1'b0;
			end else if (hold_q) begin
				// Resume once the saved one goes out
				if (!freeze_i) begin
					hold_d   = 1'b0;
					cycstb_d = cfg_i.fetch_en;
				end
			end else if (!cycstb_q || done) begin
				// Idle or just finished
				cycstb_d = cfg_i.fetch_en;
			end
		end
	end

	//////////////////////////////////////////////////
	// State
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			// Vector base resets to zero
			pc_q     <= RESET_OFFSET[31:2];
			mark_q   <= 1'b0;
			cycstb_q <= 1'b0;
			hold_q   <= 1'b0;
		end else begin
			pc_q     <= pc_d;
			mark_q   <= mark_d;
			cycstb_q <= cycstb_d;
			hold_q   <= hold_d;
		end
	end

	assign ic_req_o.cycstb = cycstb_q;
	assign ic_req_o.adr    = {pc_q, 1'b0, mark_q};

endmodule

// File: verilog/fetch_if_stage.sv
`timescale 1ns/100ps

module fetch_if_stage (
	input  logic               clk,
	input  logic               rst_n_i,
	input  fetch_pkg::ic_rsp_t ic_rsp_i,
	input  logic               freeze_i,
	input  logic               flushpipe_i,
	input  logic               rfe_i,
	input  logic               no_more_dslot_i,
	output fetch_pkg::if_out_t if_out_o,
	output logic               if_stall_o,
	output logic               saving_insn_o
);

	import isa_pkg::*;

	// Decoded fetch error flags
	typedef struct packed {
		logic itlbmiss;
		logic immufault;
		logic ibuserr;
	} if_err_t;

	logic        rsp_done;
	logic        save_insn;
	logic        bypass;
	logic        bypass_q;
	logic        squash;
	logic        saved_q;
	logic [31:0] insn_saved_q;
	logic [31:2] addr_saved_q;
	if_err_t     err_saved_q;
	if_err_t     err_rsp;
	if_err_t     err_out;

	assign rsp_done = ic_rsp_i.ack | ic_rsp_i.err;

	// Response under freeze, nothing held yet
	assign save_insn     = rsp_done & freeze_i & ~saved_q;
	assign saving_insn_o = ~flushpipe_i & save_insn;

	//////////////////////////////////////////////////
	// Bypass after flush
	//////////////////////////////////////////////////

	// Bubbles until the marked address comes back
	assign bypass = flushpipe_i | (bypass_q & ~(rsp_done & ic_rsp_i.adr[0]));

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bypass_q <= 1'b0;
		end else begin
			bypass_q <= bypass;
		end
	end

	//////////////////////////////////////////////////
	// Saved instruction
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			saved_q <= 1'b0;
		end else if (flushpipe_i) begin
			saved_q <= 1'b0;
		end else if (save_insn) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			// Delivered on the first unfrozen edge
			saved_q <= 1'b0;
		end
	end

	// Payload, qualified by saved_q
	always_ff @(posedge clk) begin
		if (saving_insn_o) begin
			insn_saved_q <= ic_rsp_i.err ? NOP_BUBBLE : ic_rsp_i.dat;
			addr_saved_q <= ic_rsp_i.adr[31:2];
			err_saved_q  <= err_rsp;
		end
	end

	//////////////////////////////////////////////////
	// Error decode
	//////////////////////////////////////////////////

	assign err_rsp.itlbmiss  = ic_rsp_i.err & (ic_rsp_i.tag == ITAG_TE);
	assign err_rsp.immufault = ic_rsp_i.err & (ic_rsp_i.tag == ITAG_PE);
	assign err_rsp.ibuserr   = ic_rsp_i.err & (ic_rsp_i.tag == ITAG_BE);

	always_comb begin
		if (no_more_dslot_i || bypass) begin
			// Killed slot or discarded response
			err_out = '0;
		end else if (saved_q) begin
			err_out = err_saved_q;
		end else begin
			err_out = err_rsp;
		end
	end

	//////////////////////////////////////////////////
	// Output to decode
	//////////////////////////////////////////////////

	assign squash = no_more_dslot_i | rfe_i | bypass;

	always_comb begin
		if (squash) begin
			if_out_o.insn = NOP_BUBBLE;
		end else if (saved_q) begin
			if_out_o.insn = insn_saved_q;
		end else if (ic_rsp_i.err) begin
			if_out_o.insn = NOP_BUBBLE;
		end else if (ic_rsp_i.ack) begin
			if_out_o.insn = ic_rsp_i.dat;
		end else begin
			if_out_o.insn = NOP_STALL;
		end
	end

	// Word aligned, marker bit dropped
	assign if_out_o.pc = saved_q ? {addr_saved_q, 2'b00} : {ic_rsp_i.adr[31:2], 2'b00};

	assign if_out_o.itlbmiss  = err_out.itlbmiss;
	assign if_out_o.immufault = err_out.immufault;
	assign if_out_o.ibuserr   = err_out.ibuserr;

	assign if_stall_o = ~rsp_done & ~saved_q;

endmodule

// File: verilog/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
	input  logic                 clk,
	input  logic                 rst_n_i,
	// Configuration access
	input  logic                 cfg_we_i,
	input  fetch_pkg::cfg_addr_e cfg_addr_i,
	input  logic [31:0]          cfg_wdata_i,
	output logic [31:0]          cfg_rdata_o,
	// Instruction cache
	output fetch_pkg::ic_req_t   ic_req_o,
	input  fetch_pkg::ic_rsp_t   ic_rsp_i,
	// Pipeline control
	input  logic                 freeze_i,
	input  logic                 redirect_i,
	input  logic [31:0]          redirect_pc_i,
	input  logic                 except_i,
	input  fetch_pkg::exc_e      except_cause_i,
	input  logic                 rfe_i,
	input  logic                 no_more_dslot_i,
	// To decode
	output fetch_pkg::if_out_t   if_out_o,
	output logic                 if_stall_o,
	output logic                 saving_insn_o
);

	import fetch_pkg::*;

	fetch_cfg_t cfg;
	logic       flushpipe;
	logic       saving;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	fetch_cfg_regs u_cfg_regs (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.cfg_we_i    (cfg_we_i),
		.cfg_addr_i  (cfg_addr_i),
		.cfg_wdata_i (cfg_wdata_i),
		.cfg_rdata_o (cfg_rdata_o),
		.cfg_o       (cfg)
	);

	// Address and request
	fetch_pc_gen u_pc_gen (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.cfg_i          (cfg),
		.ic_rsp_i       (ic_rsp_i),
		.freeze_i       (freeze_i),
		.saving_i       (saving),
		.redirect_i     (redirect_i),
		.redirect_pc_i  (redirect_pc_i),
		.except_i       (except_i),
		.except_cause_i (except_cause_i),
		.ic_req_o       (ic_req_o),
		.flushpipe_o    (flushpipe)
	);

	// Saving follows the stage, not the top output
	fetch_if_stage u_if_stage (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.ic_rsp_i        (ic_rsp_i),
		.freeze_i        (freeze_i),
		.flushpipe_i     (flushpipe),
		.rfe_i           (rfe_i),
		.no_more_dslot_i (no_more_dslot_i),
		.if_out_o        (if_out_o),
		.if_stall_o      (if_stall_o),
		.saving_insn_o   (saving)
	);

	assign saving_insn_o = saving;

endmodule

// File: verification/fetch_imem_model.sv
`timescale 1ns/100ps

module fetch_imem_model #(
	parameter logic [15:0] SEED = 16'd40928
) (
	input  logic               clk,
	input  logic               rst_n_i,
	input  fetch_pkg::ic_req_t ic_req_i,
	// Inclusive word window answered with err
	input  logic [31:0]        err_lo_i,
	input  logic [31:0]        err_hi_i,
	input  isa_pkg::itag_e     err_tag_i,
	output fetch_pkg::ic_rsp_t ic_rsp_o
);

	import isa_pkg::*;

	logic [15:0] lfsr_q;
	logic [15:0] lfsr_1;
	logic [15:0] lfsr_2;
	logic [31:0] adr_q;
	logic [1:0]  wait_q;
	logic        busy_q;
	logic        ready;
	logic        in_window;

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One step per wait bit
	assign lfsr_1 = lfsr_step(lfsr_q);
	assign lfsr_2 = lfsr_step(lfsr_1);

	always @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lfsr_q <= SEED;
			adr_q  <= '0;
			wait_q <= '0;
			busy_q <= 1'b0;
		end else if (!ic_req_i.cycstb) begin
			busy_q <= 1'b0;
		end else if (!busy_q || ic_req_i.adr != adr_q) begin
			// New address draws 0 to 3 wait cycles
			adr_q  <= ic_req_i.adr;
			wait_q <= {lfsr_q[0], lfsr_1[0]};
			lfsr_q <= lfsr_2;
			busy_q <= 1'b1;
		end else if (wait_q != 2'd0) begin
			wait_q <= wait_q - 2'd1;
		end else begin
			// Answered this cycle
			busy_q <= 1'b0;
		end
	end

	assign ready     = ic_req_i.cycstb && busy_q &&
		(ic_req_i.adr == adr_q) && (wait_q == 2'd0);
	assign in_window = ({ic_req_i.adr[31:2], 2'b00} >= err_lo_i) &&
		({ic_req_i.adr[31:2], 2'b00} <= err_hi_i);

	assign ic_rsp_o.ack = ready && !in_window;
	assign ic_rsp_o.err = ready && in_window;
	// Data keyed on the word address
	assign ic_rsp_o.dat = {ic_req_i.adr[31:1], 1'b0} ^ 32'h5A5A_0000;
	// Marker bit echoed in adr
	assign ic_rsp_o.adr = ic_req_i.adr;
	assign ic_rsp_o.tag = (ready && in_window) ? err_tag_i : ITAG_NI;

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

	import isa_pkg::*;
	import fetch_pkg::*;

	// 5 tests of about 40 fetches at 4 cycles worst case, with margin
	localparam int          TIMEOUT_CYCLES = 4000;
	localparam logic [31:0] DAT_KEY        = 32'h5A5A_0000;
	// Vector offsets in cause order
	localparam logic [31:0] CAUSE_OFFS [4] = '{32'h200, 32'h400, 32'hA00, 32'hC00};

	logic        clk;
	logic        rst_n;
	logic        cfg_we;
	cfg_addr_e   cfg_addr;
	logic [31:0] cfg_wdata;
	logic [31:0] cfg_rdata;
	ic_req_t     ic_req;
	ic_rsp_t     ic_rsp;
	logic        freeze;
	logic        redirect_pulse;
	logic [31:0] redirect_pc;
	logic        except_pulse;
	exc_e        except_cause;
	logic        rfe;
	logic        no_more_dslot;
	if_out_t     if_out;
	logic        if_stall;
	logic        saving_insn;
	logic [31:0] err_lo;
	logic [31:0] err_hi;
	itag_e       err_tag;
	if_out_t     deliv_q [$];
	int          err_cnt;
	int          check_cnt;
	int          save_cnt;
	int          cycle_cnt;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	fetch_top DUT (
		.clk (clk), .rst_n_i (rst_n),
		.cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
		.cfg_rdata_o (cfg_rdata), .ic_req_o (ic_req), .ic_rsp_i (ic_rsp),
		.freeze_i (freeze), .redirect_i (redirect_pulse), .redirect_pc_i (redirect_pc),
		.except_i (except_pulse), .except_cause_i (except_cause), .rfe_i (rfe),
		.no_more_dslot_i (no_more_dslot), .if_out_o (if_out), .if_stall_o (if_stall),
		.saving_insn_o (saving_insn)
	);

	fetch_imem_model u_imem (
		.clk (clk), .rst_n_i (rst_n), .ic_req_i (ic_req),
		.err_lo_i (err_lo), .err_hi_i (err_hi), .err_tag_i (err_tag), .ic_rsp_o (ic_rsp)
	);

	//////////////////////////////////////////////////
	// Delivery collection and watchdog
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rst_n) begin
			cycle_cnt++;
			// Decode takes it on an unstalled, unfrozen edge
			if (!if_stall && !freeze) begin
				deliv_q.push_back(if_out);
			end
			if (saving_insn) begin
				save_cnt++;
			end
		end
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_cnt++;
		if (exp !== act) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic pop_delivery(output if_out_t d);
		while (deliv_q.size() == 0) begin
			@(negedge clk);
		end
		d = deliv_q.pop_front();
	endtask

	// Skip bubbles left by a flush
	task automatic pop_real(output if_out_t d);
		pop_delivery(d);
		while (d.insn == NOP_BUBBLE) begin
			pop_delivery(d);
		end
	endtask

	// Consecutive words from first_pc, clean data and flags
	task automatic check_stream(input string name, input logic [31:0] first_pc, input int n);
		if_out_t     d;
		logic [31:0] pc;
		pc = first_pc;
		for (int i = 0; i < n; i++) begin
			if (i == 0) begin
				pop_real(d);
			end else begin
				pop_delivery(d);
			end
			check_word({name, " pc"}, pc, d.pc);
			check_word({name, " insn"}, pc ^ DAT_KEY, d.insn);
			check_word({name, " flags"}, 32'd0, {29'd0, d.itlbmiss, d.immufault, d.ibuserr});
			pc = pc + 32'd4;
		end
	endtask

	// One-cycle redirect or exception, then drop stale deliveries
	task automatic flush_to(input logic is_exc, input logic [31:0] target, input exc_e cause);
		@(negedge clk);
		redirect_pc    = target;
		except_cause   = cause;
		except_pulse   = is_exc;
		redirect_pulse = !is_exc;
		@(negedge clk);
		except_pulse   = 1'b0;
		redirect_pulse = 1'b0;
		deliv_q.delete();
	endtask

	task automatic write_cfg(input cfg_addr_e addr, input logic [31:0] data);
		@(negedge clk);
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic read_cfg(input cfg_addr_e addr, output logic [31:0] data);
		@(negedge clk);
		cfg_addr = addr;
		@(posedge clk);
		data = cfg_rdata;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic sequential_fetch();
		check_stream("sequential", 32'h0000_0100, 16);
	endtask

	// Three freezes, each long enough to catch one fetch
	task automatic freeze_hold();
		int base;
		base = save_cnt;
		for (int k = 0; k < 3; k++) begin
			@(negedge clk);
			while (!ic_req.cycstb) begin
				@(negedge clk);
			end
			freeze = 1'b1;
			repeat (6) @(negedge clk);
			freeze = 1'b0;
			repeat (3 + k) @(negedge clk);
		end
		check_word("freeze saves", 32'd3, save_cnt - base);
		// Picks up right after the sequential test
		check_stream("freeze", 32'h0000_0140, 24);
	endtask

	task automatic fetch_errors();
		if_out_t     d;
		logic [31:0] adr;
		for (int k = 0; k < 3; k++) begin
			adr     = 32'h0000_3000 + 32'h10 * k;
			err_lo  = adr;
			err_hi  = adr;
			// TE, PE, BE in turn
			err_tag = itag_e'(4'hD - 4'(k));
			for (int s = 0; s < 2; s++) begin
				no_more_dslot = (s == 1);
				flush_to(1'b0, adr | 32'd1, EXC_BUS);
				pop_delivery(d);
				check_word("error pc", adr, d.pc);
				check_word("error insn", NOP_BUBBLE, d.insn);
				check_word("error flags", (s == 1) ? 32'd0 : {29'd0, 3'b100 >> k},
					{29'd0, d.itlbmiss, d.immufault, d.ibuserr});
			end
		end
		no_more_dslot = 1'b0;
		err_lo        = '1;
		err_hi        = '0;
		// Return from exception squashes too
		rfe = 1'b1;
		flush_to(1'b0, 32'h0000_3101, EXC_BUS);
		pop_delivery(d);
		check_word("rfe pc", 32'h0000_3100, d.pc);
		check_word("rfe insn", NOP_BUBBLE, d.insn);
		rfe = 1'b0;
	endtask

	task automatic redirect_stream();
		flush_to(1'b0, 32'h0000_2345, EXC_BUS);
		check_stream("redirect", 32'h0000_2344, 8);
	endtask

	task automatic config_and_exceptions();
		if_out_t     d;
		logic [31:0] rd;
		logic [31:0] evbar;
		write_cfg(CFG_EVBAR, 32'h0002_0000);
		read_cfg(CFG_EVBAR, rd);
		check_word("evbar", 32'h0002_0000, rd);
		write_cfg(CFG_EVBAR, 32'h0004_5678);
		read_cfg(CFG_EVBAR, rd);
		evbar = 32'h0004_5678 & ~32'h0000_1FFF;
		check_word("evbar unaligned", evbar, rd);
		for (int c = 0; c < 4; c++) begin
			flush_to(1'b1, 32'd0, exc_e'(c));
			pop_real(d);
			check_word("exception pc", evbar + CAUSE_OFFS[c], d.pc);
		end
		write_cfg(CFG_CTRL, 32'd0);
		read_cfg(CFG_CTRL, rd);
		check_word("ctrl", 32'd0, rd);
		// Fetch in flight finishes first
		while (ic_req.cycstb) begin
			@(negedge clk);
		end
		repeat (20) begin
			@(negedge clk);
			check_word("disabled stall", 32'd1, {31'd0, if_stall});
			check_word("disabled cycstb", 32'd0, {31'd0, ic_req.cycstb});
		end
	endtask

	initial begin
		rst_n          = 1'b0;
		cfg_we         = 1'b0;
		cfg_addr       = CFG_EVBAR;
		cfg_wdata      = '0;
		freeze         = 1'b0;
		redirect_pulse = 1'b0;
		redirect_pc    = '0;
		except_pulse   = 1'b0;
		except_cause   = EXC_BUS;
		rfe            = 1'b0;
		no_more_dslot  = 1'b0;
		// Empty error window
		err_lo         = '1;
		err_hi         = '0;
		err_tag        = ITAG_NI;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		sequential_fetch();
		freeze_hold();
		fetch_errors();
		redirect_stream();
		config_and_exceptions();
		err_lo = '1;
		err_hi = '0;
		$display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: files.f
verilog/isa_pkg.sv
verilog/fetch_pkg.sv
verilog/fetch_cfg_regs.sv
verilog/fetch_pc_gen.sv
verilog/fetch_if_stage.sv
verilog/fetch_top.sv
verification/fetch_imem_model.sv
verification/fetch_tb.sv

// File: Makefile
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: obj_dir/Vfetch_tb

obj_dir/Vfetch_tb: files.f $(SRCS)
	verilator --binary --timing --top-module fetch_tb -f files.f -o Vfetch_tb

run: obj_dir/Vfetch_tb
	@out="$$(./obj_dir/Vfetch_tb)"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
